// ==== logic/mem_pkg.sv ====
// Memory stage shared definitions
`default_nettype none

package mem_pkg;

    // ----------------------------------------
    // Memory geometry
    // ----------------------------------------

    // Data memory depth in 32-bit words
    localparam int D_MEM_WORDS = 1024;
    // Word address covers the whole array
    localparam int WORD_ADDR_W = 10;
    // Core byte address, two extra offset bits
    localparam int BYTE_ADDR_W = 12;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    typedef logic [31:0]            word_t;
    // Bit i enables byte lane i
    typedef logic [3:0]             byte_en_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;

    // Access size, same codes as RISC-V funct3
    typedef enum logic [2:0] {
        SZ_B  = 3'd0,
        SZ_H  = 3'd1,
        SZ_W  = 3'd2,
        SZ_BU = 3'd4,
        SZ_HU = 3'd5
    } ls_size_t;

    // Host port handshake FSM
    typedef enum logic [1:0] {
        HP_IDLE,
        HP_ACCESS,
        HP_CAPTURE,
        HP_ACK
    } host_state_t;

endpackage

`default_nettype wire

// ==== logic/d_mem.sv ====
// Dual-port data memory
`default_nettype none

module d_mem (
    input  logic                clock,
    input  mem_pkg::word_addr_t address_a,
    input  mem_pkg::word_addr_t address_b,
    input  mem_pkg::word_t      data_a,
    input  mem_pkg::word_t      data_b,
    input  mem_pkg::byte_en_t   byteena_a,
    input  mem_pkg::byte_en_t   byteena_b,
    input  logic                wren_a,
    input  logic                wren_b,
    output mem_pkg::word_t      q_a,
    output mem_pkg::word_t      q_b
);

    // Behavioral byte array, one entry per byte
    logic [7:0] mem [0:mem_pkg::D_MEM_WORDS*4-1];

    // Byte index of one lane inside a word
    function automatic mem_pkg::byte_addr_t lane_addr(
        input mem_pkg::word_addr_t word_addr,
        input logic [1:0]          lane
    );
        lane_addr = {word_addr, lane};
    endfunction

    // ----------------------------------------
    // Byte-enabled writes
    // ----------------------------------------

    // Port A first, then port B
    // Later nonblocking update wins, so host beats core on a shared byte
    always_ff @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (wren_a && byteena_a[i]) begin
                mem[lane_addr(address_a, 2'(i))] <= data_a[8*i +: 8];
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (wren_b && byteena_b[i]) begin
                mem[lane_addr(address_b, 2'(i))] <= data_b[8*i +: 8];
            end
        end
    end

    // ----------------------------------------
    // Registered reads
    // ----------------------------------------

    // Sampled before this edge's writes land
    // Read-during-write returns old data
    always_ff @(posedge clock) begin
        q_a <= {mem[lane_addr(address_a, 2'd3)],
                mem[lane_addr(address_a, 2'd2)],
                mem[lane_addr(address_a, 2'd1)],
                mem[lane_addr(address_a, 2'd0)]};
        q_b <= {mem[lane_addr(address_b, 2'd3)],
                mem[lane_addr(address_b, 2'd2)],
                mem[lane_addr(address_b, 2'd1)],
                mem[lane_addr(address_b, 2'd0)]};
    end

endmodule

`default_nettype wire

// ==== logic/lsu.sv ====
// Core load/store unit
`default_nettype none

module lsu (
    input  logic                clock,
    input  logic                reset,
    // Core request, one cycle per access
    input  logic                core_valid,
    input  logic                core_write,
    input  mem_pkg::ls_size_t   core_size,
    input  mem_pkg::byte_addr_t core_addr,
    input  mem_pkg::word_t      core_wdata,
    output logic                core_misaligned,
    output logic                core_rvalid,
    output mem_pkg::word_t      core_rdata,
    // Memory port A
    output mem_pkg::word_addr_t mem_addr,
    output mem_pkg::word_t      mem_wdata,
    output mem_pkg::byte_en_t   mem_be,
    output logic                mem_wren,
    input  mem_pkg::word_t      mem_q
);

    // Byte offset within the word
    logic [1:0]        offset;
    // Alignment fault for the decoded size
    logic              bad_align;

    // Load info carried to the data cycle
    logic              ld_valid;
    mem_pkg::ls_size_t ld_size;
    logic [1:0]        ld_offset;
    mem_pkg::word_t    ld_shifted;

    assign offset   = core_addr[1:0];
    assign mem_addr = core_addr[mem_pkg::BYTE_ADDR_W-1:2];

    // ----------------------------------------
    // Request decode
    // ----------------------------------------

    always_comb begin
        case (core_size)
            mem_pkg::SZ_B, mem_pkg::SZ_BU: begin
                // Byte in every lane, enable picks one
                mem_be    = 4'b0001 << offset;
                mem_wdata = {4{core_wdata[7:0]}};
                bad_align = 1'b0;
            end
            mem_pkg::SZ_H, mem_pkg::SZ_HU: begin
                // Half must start on an even byte
                mem_be    = 4'b0011 << offset;
                mem_wdata = {2{core_wdata[15:0]}};
                bad_align = offset[0];
            end
            default: begin
                // Word, only offset zero is legal
                mem_be    = 4'b1111;
                mem_wdata = core_wdata;
                bad_align = (offset != 2'd0);
            end
        endcase
    end

    assign core_misaligned = core_valid && bad_align;
    // Misaligned stores never reach memory
    assign mem_wren = core_valid && core_write && !bad_align;

    // ----------------------------------------
    // Load tracking
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= core_valid && !core_write && !bad_align;
        end
    end

    // Payload only, qualified by ld_valid
    always_ff @(posedge clock) begin
        ld_size   <= core_size;
        ld_offset <= offset;
    end

    // ----------------------------------------
    // Load alignment and extension
    // ----------------------------------------

    always_comb begin
        // Selected lane down to bit 0
        ld_shifted = mem_q >> {ld_offset, 3'b000};
        case (ld_size)
            mem_pkg::SZ_B:  core_rdata = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
            mem_pkg::SZ_BU: core_rdata = {24'd0, ld_shifted[7:0]};
            mem_pkg::SZ_H:  core_rdata = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
            mem_pkg::SZ_HU: core_rdata = {16'd0, ld_shifted[15:0]};
            default:        core_rdata = ld_shifted;
        endcase
    end

    // Result one cycle after request
    assign core_rvalid = ld_valid;

endmodule

`default_nettype wire

// ==== logic/host_port.sv ====
// Host req/ack port
`default_nettype none

module host_port (
    input  logic                clock,
    input  logic                reset,
    // Host side, four-phase handshake
    input  logic                host_req,
    input  logic                host_write,
    input  mem_pkg::word_addr_t host_addr,
    input  mem_pkg::byte_en_t   host_be,
    input  mem_pkg::word_t      host_wdata,
    output logic                host_ack,
    output mem_pkg::word_t      host_rdata,
    // Memory port B
    output mem_pkg::word_addr_t mem_addr,
    output mem_pkg::word_t      mem_wdata,
    output mem_pkg::byte_en_t   mem_be,
    output logic                mem_wren,
    input  mem_pkg::word_t      mem_q
);

    mem_pkg::host_state_t state;
    mem_pkg::host_state_t state_next;

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            // Wait for a new request
            mem_pkg::HP_IDLE:    if (host_req) state_next = mem_pkg::HP_ACCESS;
            // Memory access issued this cycle
            mem_pkg::HP_ACCESS:  state_next = mem_pkg::HP_CAPTURE;
            // Read data arrives from port B
            mem_pkg::HP_CAPTURE: state_next = mem_pkg::HP_ACK;
            // Hold ack until host drops req
            mem_pkg::HP_ACK:     if (!host_req) state_next = mem_pkg::HP_IDLE;
            default:             state_next = mem_pkg::HP_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mem_pkg::HP_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // Port B drive
    // ----------------------------------------

    // Host holds request fields stable until ack
    assign mem_addr  = host_addr;
    assign mem_wdata = host_wdata;
    assign mem_be    = host_be;
    // Single write pulse per transfer
    assign mem_wren  = (state == mem_pkg::HP_ACCESS) && host_write;

    // Registered q_b is valid in HP_CAPTURE
    always_ff @(posedge clock) begin
        if (state == mem_pkg::HP_CAPTURE) begin
            host_rdata <= mem_q;
        end
    end

    assign host_ack = (state == mem_pkg::HP_ACK);

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
// Memory stage top level
`default_nettype none

module mem_stage (
    input  logic                clock,
    input  logic                reset,
    // Core port
    input  logic                core_valid,
    input  logic                core_write,
    input  mem_pkg::ls_size_t   core_size,
    input  mem_pkg::byte_addr_t core_addr,
    input  mem_pkg::word_t      core_wdata,
    output logic                core_misaligned,
    output logic                core_rvalid,
    output mem_pkg::word_t      core_rdata,
    // Host port
    input  logic                host_req,
    input  logic                host_write,
    input  mem_pkg::word_addr_t host_addr,
    input  mem_pkg::byte_en_t   host_be,
    input  mem_pkg::word_t      host_wdata,
    output logic                host_ack,
    output mem_pkg::word_t      host_rdata
);

    // ----------------------------------------
    // Port A, core side
    // ----------------------------------------

    mem_pkg::word_addr_t a_addr;
    mem_pkg::word_t      a_wdata;
    mem_pkg::byte_en_t   a_be;
    logic                a_wren;
    mem_pkg::word_t      a_q;

    // ----------------------------------------
    // Port B, host side
    // ----------------------------------------

    mem_pkg::word_addr_t b_addr;
    mem_pkg::word_t      b_wdata;
    mem_pkg::byte_en_t   b_be;
    logic                b_wren;
    mem_pkg::word_t      b_q;

    lsu i_lsu (
        .clock           (clock),
        .reset           (reset),
        .core_valid      (core_valid),
        .core_write      (core_write),
        .core_size       (core_size),
        .core_addr       (core_addr),
        .core_wdata      (core_wdata),
        .core_misaligned (core_misaligned),
        .core_rvalid     (core_rvalid),
        .core_rdata      (core_rdata),
        .mem_addr        (a_addr),
        .mem_wdata       (a_wdata),
        .mem_be          (a_be),
        .mem_wren        (a_wren),
        .mem_q           (a_q)
    );

    host_port i_host_port (
        .clock      (clock),
        .reset      (reset),
        .host_req   (host_req),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_be    (host_be),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .mem_addr   (b_addr),
        .mem_wdata  (b_wdata),
        .mem_be     (b_be),
        .mem_wren   (b_wren),
        .mem_q      (b_q)
    );

    // Host on port B so it wins byte conflicts
    d_mem i_d_mem (
        .clock     (clock),
        .address_a (a_addr),
        .address_b (b_addr),
        .data_a    (a_wdata),
        .data_b    (b_wdata),
        .byteena_a (a_be),
        .byteena_b (b_be),
        .wren_a    (a_wren),
        .wren_b    (b_wren),
        .q_a       (a_q),
        .q_b       (b_q)
    );

endmodule

`default_nettype wire

// ==== tb/mem_stage_sva.sv ====
// Memory stage handshake assertions
`default_nettype none

module mem_stage_sva (
    input logic                 clock,
    input logic                 reset,
    input logic                 host_req,
    input logic                 host_ack,
    input logic                 core_rvalid,
    input mem_pkg::host_state_t host_state
);

    // ----------------------------------------
    // Host four-phase handshake
    // ----------------------------------------

    // Ack only answers a live request
    ack_needs_req: assert property (
        @(posedge clock) disable iff (reset) $rose(host_ack) |-> host_req
    ) else $error("host_ack rose while host_req was low");

    // No release of ack before req drops
    ack_holds: assert property (
        @(posedge clock) disable iff (reset) (host_ack && host_req) |=> host_ack
    ) else $error("host_ack fell while host_req was still high");

    // Outputs quiet and host FSM idle right after reset
    reset_quiet: assert property (
        @(posedge clock) reset |=> (!core_rvalid && !host_ack
                                    && host_state == mem_pkg::HP_IDLE)
    ) else $error("core_rvalid, host_ack or host port state wrong after reset");

endmodule

bind mem_stage mem_stage_sva i_sva (
    .clock       (clock),
    .reset       (reset),
    .host_req    (host_req),
    .host_ack    (host_ack),
    .core_rvalid (core_rvalid),
    .host_state  (i_host_port.state)
);

`default_nettype wire

// ==== tb/mem_stage_tb.sv ====
// Memory stage testbench
`default_nettype none

module mem_stage_tb;

    // ----------------------------------------
    // Run lengths and cycle limit
    // ----------------------------------------

    // Cycles per host transfer, request to ack low
    localparam int HOST_TICKS = 6;
    localparam int N_LOADS    = 600;
    localparam int N_STORES   = 200;
    localparam int N_MISALIGN = 100;
    localparam int N_MIX      = 1500;
    localparam int MAX_CYCLES = 2 * mem_pkg::D_MEM_WORDS * HOST_TICKS + N_LOADS
                              + 3 * N_STORES + 2 * N_MISALIGN + N_MIX + 200;

    // Host sequencer phases
    localparam int PH_IDLE    = 0;
    localparam int PH_WAIT    = 1;
    localparam int PH_RELEASE = 2;
    localparam int PH_LOW     = 3;

    logic                clock;
    logic                reset;
    logic                core_valid;
    logic                core_write;
    mem_pkg::ls_size_t   core_size;
    mem_pkg::byte_addr_t core_addr;
    mem_pkg::word_t      core_wdata;
    logic                core_misaligned;
    logic                core_rvalid;
    mem_pkg::word_t      core_rdata;
    logic                host_req;
    logic                host_write;
    mem_pkg::word_addr_t host_addr;
    mem_pkg::byte_en_t   host_be;
    mem_pkg::word_t      host_wdata;
    logic                host_ack;
    mem_pkg::word_t      host_rdata;

    // Reference byte array and bookkeeping
    logic [7:0]          ref_mem [0:mem_pkg::D_MEM_WORDS*4-1];
    logic [31:0]         rng_state;
    int                  tick_count;
    int                  failures;
    bit                  run_complete;
    // Load expected in the next cycle
    logic                pend_load;
    mem_pkg::word_t      pend_data;
    // Host transfer in flight
    int                  h_phase;
    int                  h_age;
    logic                h_start;
    logic                h_write;
    mem_pkg::word_addr_t h_addr;
    mem_pkg::byte_en_t   h_be;
    mem_pkg::word_t      h_wdata;
    mem_pkg::word_t      h_exp;

    mem_stage i_dut (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // ----------------------------------------
    // Compare tasks and random source
    // ----------------------------------------

    task automatic check_word(input mem_pkg::word_t got, input mem_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            failures++;
            run_complete = 1'b1;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            failures++;
            run_complete = 1'b1;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic mem_pkg::ls_size_t load_size(input logic [31:0] r);
        case (r % 32'd5)
            32'd0:   load_size = mem_pkg::SZ_B;
            32'd1:   load_size = mem_pkg::SZ_BU;
            32'd2:   load_size = mem_pkg::SZ_H;
            32'd3:   load_size = mem_pkg::SZ_HU;
            default: load_size = mem_pkg::SZ_W;
        endcase
    endfunction

    function automatic mem_pkg::ls_size_t store_size(input logic [31:0] r);
        case (r % 32'd3)
            32'd0:   store_size = mem_pkg::SZ_B;
            32'd1:   store_size = mem_pkg::SZ_H;
            default: store_size = mem_pkg::SZ_W;
        endcase
    endfunction

    // Halves on even bytes, words on multiples of four
    function automatic logic is_misaligned(input mem_pkg::ls_size_t size,
                                           input mem_pkg::byte_addr_t addr);
        case (size)
            mem_pkg::SZ_H, mem_pkg::SZ_HU: is_misaligned = addr[0];
            mem_pkg::SZ_W:                 is_misaligned = (addr[1:0] != 2'd0);
            default:                       is_misaligned = 1'b0;
        endcase
    endfunction

    function automatic mem_pkg::byte_addr_t align_addr(input mem_pkg::ls_size_t size,
                                                       input mem_pkg::byte_addr_t addr);
        case (size)
            mem_pkg::SZ_H, mem_pkg::SZ_HU: align_addr = addr & ~mem_pkg::byte_addr_t'(1);
            mem_pkg::SZ_W:                 align_addr = addr & ~mem_pkg::byte_addr_t'(3);
            default:                       align_addr = addr;
        endcase
    endfunction

    function automatic mem_pkg::byte_addr_t misalign_addr(input mem_pkg::ls_size_t size,
            input mem_pkg::byte_addr_t addr, input logic [31:0] r);
        if (size == mem_pkg::SZ_W) begin
            misalign_addr = {addr[mem_pkg::BYTE_ADDR_W-1:2], (r[4:3] == 2'd0) ? 2'd1 : r[4:3]};
        end else begin
            misalign_addr = addr | mem_pkg::byte_addr_t'(1);
        end
    endfunction

    // Small word window so both ports collide often
    function automatic mem_pkg::word_addr_t window_word(input logic [31:0] r);
        window_word = mem_pkg::word_addr_t'(r % 32'd16);
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Byte at its address, half in its lane, then extend
    function automatic mem_pkg::word_t model_load(input mem_pkg::ls_size_t size,
                                                  input mem_pkg::byte_addr_t addr);
        mem_pkg::word_addr_t wa;
        logic [31:0]         w0;
        logic [15:0]         h0;
        logic [7:0]          b0;
        wa = addr[mem_pkg::BYTE_ADDR_W-1:2];
        w0 = {ref_mem[{wa, 2'd3}], ref_mem[{wa, 2'd2}], ref_mem[{wa, 2'd1}], ref_mem[{wa, 2'd0}]};
        h0 = addr[1] ? w0[31:16] : w0[15:0];
        b0 = ref_mem[addr];
        case (size)
            mem_pkg::SZ_B:  model_load = {{24{b0[7]}}, b0};
            mem_pkg::SZ_BU: model_load = {24'd0, b0};
            mem_pkg::SZ_H:  model_load = {{16{h0[15]}}, h0};
            mem_pkg::SZ_HU: model_load = {16'd0, h0};
            default:        model_load = w0;
        endcase
    endfunction

    function automatic void model_store(input mem_pkg::ls_size_t size,
                                        input mem_pkg::byte_addr_t addr,
                                        input mem_pkg::word_t wdata);
        case (size)
            mem_pkg::SZ_B: ref_mem[addr] = wdata[7:0];
            mem_pkg::SZ_H: begin
                ref_mem[{addr[mem_pkg::BYTE_ADDR_W-1:1], 1'b0}] = wdata[7:0];
                ref_mem[{addr[mem_pkg::BYTE_ADDR_W-1:1], 1'b1}] = wdata[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{addr[mem_pkg::BYTE_ADDR_W-1:2], 2'(i)}] = wdata[8*i +: 8];
                end
            end
        endcase
    endfunction

    function automatic void model_host_write();
        for (int i = 0; i < 4; i++) begin
            if (h_be[i]) begin
                ref_mem[{h_addr, 2'(i)}] = h_wdata[8*i +: 8];
            end
        end
    endfunction

    // ----------------------------------------
    // Host sequencer
    // ----------------------------------------

    function automatic void start_host(input logic write, input mem_pkg::word_addr_t addr,
                                       input mem_pkg::byte_en_t be, input mem_pkg::word_t wdata);
        h_start = 1'b1;
        h_write = write;
        h_addr  = addr;
        h_be    = be;
        h_wdata = wdata;
    endfunction

    // Runs on the rising edge
    task automatic drive_host();
        if (h_phase == PH_IDLE && h_start) begin
            host_req   <= 1'b1;
            host_write <= h_write;
            host_addr  <= h_addr;
            host_be    <= h_be;
            host_wdata <= h_wdata;
            h_start = 1'b0;
            h_phase = PH_WAIT;
            h_age   = -1;
        end else if (h_phase == PH_WAIT && h_age == 3) begin
            host_req <= 1'b0;
            h_phase = PH_RELEASE;
        end
    endtask

    // Age 1 is the port B access cycle, ack due at age 3
    task automatic check_host();
        case (h_phase)
            PH_WAIT: begin
                h_age++;
                check_flag(host_ack, h_age == 3, "host_ack");
                if (h_age == 1 && !h_write) begin
                    h_exp = model_load(mem_pkg::SZ_W, {h_addr, 2'b00});
                end
                if (h_age == 3 && !h_write) begin
                    check_word(host_rdata, h_exp, "host_rdata");
                end
            end
            PH_RELEASE: begin
                check_flag(host_ack, 1'b1, "host_ack before req seen low");
                h_phase = PH_LOW;
            end
            default: begin
                check_flag(host_ack, 1'b0, "host_ack");
                h_phase = PH_IDLE;
            end
        endcase
    endtask

    // ----------------------------------------
    // One clock cycle of stimulus and checks
    // ----------------------------------------

    task automatic tick(input logic c_valid, input logic c_write, input mem_pkg::ls_size_t c_size,
                        input mem_pkg::byte_addr_t c_addr, input mem_pkg::word_t c_wdata);
        logic mis;
        mis = c_valid && is_misaligned(c_size, c_addr);
        tick_count++;
        if (tick_count > MAX_CYCLES) begin
            run_complete = 1'b1;
            $display("Timeout after %0d cycles, the test sequence did not finish", tick_count);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
        @(posedge clock);
        core_valid <= c_valid;
        core_write <= c_write;
        core_size  <= c_size;
        core_addr  <= c_addr;
        core_wdata <= c_wdata;
        drive_host();
        // Outputs settled, mid cycle
        @(negedge clock);
        check_flag(core_misaligned, mis, "core_misaligned");
        check_flag(core_rvalid, pend_load, "core_rvalid");
        if (pend_load) begin
            check_word(core_rdata, pend_data, "core_rdata");
        end
        // Loads see memory before this cycle's writes
        pend_load = c_valid && !c_write && !mis;
        if (pend_load) begin
            pend_data = model_load(c_size, c_addr);
        end
        check_host();
        // Core store first, host write last so host wins
        if (c_valid && c_write && !mis) begin
            model_store(c_size, c_addr, c_wdata);
        end
        if (h_phase == PH_WAIT && h_age == 1 && h_write) begin
            model_host_write();
        end
    endtask

    task automatic idle_tick();
        tick(1'b0, 1'b0, mem_pkg::SZ_W, '0, '0);
    endtask

    task automatic core_load(input mem_pkg::ls_size_t size, input mem_pkg::byte_addr_t addr);
        tick(1'b1, 1'b0, size, addr, '0);
    endtask

    task automatic core_store(input mem_pkg::ls_size_t size, input mem_pkg::byte_addr_t addr,
                              input mem_pkg::word_t wdata);
        tick(1'b1, 1'b1, size, addr, wdata);
    endtask

    task automatic host_transfer(input logic write, input mem_pkg::word_addr_t addr,
                                 input mem_pkg::byte_en_t be, input mem_pkg::word_t wdata);
        start_host(write, addr, be, wdata);
        idle_tick();
        while (h_phase != PH_IDLE) begin
            idle_tick();
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        mem_pkg::word_t      r;
        mem_pkg::ls_size_t   size;
        mem_pkg::byte_addr_t addr;
        rng_state    = 32'haa5158d1;
        tick_count   = 0;
        failures     = 0;
        run_complete = 1'b0;
        pend_load    = 1'b0;
        pend_data    = '0;
        h_phase      = PH_IDLE;
        h_age        = 0;
        h_start      = 1'b0;
        reset      <= 1'b1;
        core_valid <= 1'b0;
        core_write <= 1'b0;
        core_size  <= mem_pkg::SZ_W;
        core_addr  <= '0;
        core_wdata <= '0;
        host_req   <= 1'b0;
        host_write <= 1'b0;
        host_addr  <= '0;
        host_be    <= '0;
        host_wdata <= '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // Host fill then readback of every word
        for (int w = 0; w < mem_pkg::D_MEM_WORDS; w++) begin
            host_transfer(1'b1, mem_pkg::word_addr_t'(w), 4'b1111, lcg_next());
        end
        for (int w = 0; w < mem_pkg::D_MEM_WORDS; w++) begin
            host_transfer(1'b0, mem_pkg::word_addr_t'(w), 4'b1111, '0);
        end

        // Back to back loads, rare gaps
        for (int n = 0; n < N_LOADS; n++) begin
            r    = lcg_next();
            size = load_size(r);
            addr = align_addr(size, mem_pkg::byte_addr_t'(lcg_next()));
            if (r[31:28] == 4'd0) begin
                idle_tick();
            end else begin
                core_load(size, addr);
            end
        end

        // Narrow stores, then whole word and sized reload
        for (int n = 0; n < N_STORES; n++) begin
            r = lcg_next();
            if (r[8]) begin
                size = mem_pkg::SZ_H;
            end else begin
                size = mem_pkg::SZ_B;
            end
            addr = align_addr(size, mem_pkg::byte_addr_t'(lcg_next()));
            core_store(size, addr, lcg_next());
            core_load(mem_pkg::SZ_W, align_addr(mem_pkg::SZ_W, addr));
            core_load(load_size(r), align_addr(load_size(r), addr));
        end

        // Misaligned access, then reload of its word
        for (int n = 0; n < N_MISALIGN; n++) begin
            r = lcg_next();
            if (r[0]) begin
                size = mem_pkg::SZ_W;
            end else if (r[1] && !r[2]) begin
                size = mem_pkg::SZ_HU;
            end else begin
                size = mem_pkg::SZ_H;
            end
            addr = misalign_addr(size, mem_pkg::byte_addr_t'(lcg_next()), r);
            if (r[2]) begin
                core_store(size, addr, lcg_next());
            end else begin
                core_load(size, addr);
            end
            core_load(mem_pkg::SZ_W, align_addr(mem_pkg::SZ_W, addr));
        end

        // Core and host together on a small window
        for (int n = 0; n < N_MIX; n++) begin
            r = lcg_next();
            if (h_phase == PH_IDLE && !h_start) begin
                start_host(r[0], window_word(lcg_next()), r[4:1], lcg_next());
            end
            r    = lcg_next();
            addr = {window_word(lcg_next()), r[9:8]};
            if (h_phase == PH_WAIT && h_age == 0 && h_write && r[0]) begin
                // Same word as the host write landing next edge
                size = store_size(r);
                core_store(size, align_addr(size, {h_addr, r[9:8]}), lcg_next());
            end else if (r[1]) begin
                size = load_size(r);
                core_load(size, align_addr(size, addr));
            end else if (r[2]) begin
                size = store_size(r);
                core_store(size, align_addr(size, addr), lcg_next());
            end else begin
                idle_tick();
            end
        end
        while (h_phase != PH_IDLE || h_start) begin
            idle_tick();
        end
        idle_tick();

        run_complete = 1'b1;
        if (failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Run stopped early, e.g. by an assertion
    final begin
        if (!run_complete) begin
            $display("Checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/mem_pkg.sv
logic/d_mem.sv
logic/lsu.sv
logic/host_port.sv
logic/mem_stage.sv
tb/mem_stage_sva.sv
tb/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_stage_tb \
    -f sim.f -o mem_stage_sim \
    && ./obj_dir/mem_stage_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
